//--- sim.f
rtl/cart_pkg.sv
rtl/n64_pi_frontend.sv
rtl/pi_request_fifo.sv
rtl/cart_memory_ctrl.sv
rtl/cart_pi_top.sv
tb/cart_pi_assertions.sv
tb/tb_cart_pi.sv

//--- Makefile
TOP := tb_cart_pi

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- tb/tb_cart_pi.sv
`timescale 1ns/10ps

module tb_cart_pi;

    localparam int          CLK_PERIOD   = 20;
    localparam logic [15:0] LFSR_SEED    = 16'd36;
    localparam logic [15:0] LFSR_TAPS    = 16'hB400;
    localparam int          N_RANDOM     = 64;
    localparam int          N_BURST      = 16;
    localparam int          N_UNMAPPED   = 16;
    localparam int          N_ORDER      = 4;
    localparam int          READ_TIMEOUT = 20;  // Cycles from read_n low to the bus drive.
    localparam int          TOTAL_OPS    = 2 * N_RANDOM + 2 * N_BURST + 4 + 3 * N_UNMAPPED
                                           + 4 * N_ORDER;

    logic        clk;
    logic        rst_n;
    logic        pi_aleh;
    logic        pi_alel;
    logic        pi_read_n;
    logic        pi_write_n;
    logic [15:0] pi_ad_in;
    logic [15:0] pi_ad_out;
    logic        pi_ad_oe;
    logic        n64_irq;
    logic [15:0] lfsr_state = LFSR_SEED;
    logic [15:0] model_mem [256];
    logic        model_irq;
    logic [31:0] shadow_addr;  // Follows the frontend's +2 rule.
    logic [31:0] pending [$];
    logic [7:0]  written [$];

    cart_pi_top DUT (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_pi_aleh(pi_aleh), .i_pi_alel(pi_alel),
        .i_pi_read_n(pi_read_n), .i_pi_write_n(pi_write_n),
        .i_pi_ad(pi_ad_in), .o_pi_ad(pi_ad_out), .o_pi_ad_oe(pi_ad_oe),
        .o_n64_irq(n64_irq)
    );

    bind pi_request_fifo cart_pi_assertions fifo_checks (
        .i_clk, .i_rst_n, .i_push, .i_pop,
        .i_full(o_full), .i_empty(o_empty), .i_count(count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_step()};
        end
        return value;
    endfunction

    // Expected read data for a PI address.
    function automatic logic [15:0] model_read(input logic [31:0] addr);
        if (addr[31:28] == cart_pkg::REGION_ROM) begin
            return model_mem[addr[8:1]];
        end else if (addr[31:28] == cart_pkg::REGION_CFG && addr[8:1] == 8'd0) begin
            return {15'd0, model_irq};
        end
        return 16'd0;
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic check_value(input logic [15:0] got, input logic [15:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic pi_set_addr(input logic [31:0] addr);
        @(negedge clk);
        pi_aleh  = 1'b1;
        pi_ad_in = addr[31:16];
        repeat (2) @(negedge clk);
        pi_aleh  = 1'b0;
        pi_alel  = 1'b1;
        pi_ad_in = addr[15:0];
        repeat (2) @(negedge clk);
        pi_alel     = 1'b0;
        shadow_addr = addr;
    endtask

    task automatic pi_write(input logic [15:0] data);
        @(negedge clk);
        pi_ad_in   = data;
        pi_write_n = 1'b0;
        repeat (3) @(negedge clk);
        pi_write_n = 1'b1;  // Data stays on AD through the rising edge.
        repeat (4) @(negedge clk);
        if (shadow_addr[31:28] == cart_pkg::REGION_ROM) begin
            model_mem[shadow_addr[8:1]] = data;
        end else if (shadow_addr[31:28] == cart_pkg::REGION_CFG && shadow_addr[8:1] == 8'd0) begin
            model_irq = data[0];
        end
        shadow_addr = shadow_addr + 32'd2;
    endtask

    task automatic pi_read(output logic [15:0] data);
        int cycles;
        @(negedge clk);
        pi_read_n = 1'b0;
        cycles    = 0;
        while (pi_ad_oe !== 1'b1 && cycles < READ_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (pi_ad_oe !== 1'b1) begin
            $display("ERROR at %0t ns: the cartridge never drove read data", $time);
            abort_run();
        end
        data      = pi_ad_out;
        pi_read_n = 1'b1;
        repeat (4) @(negedge clk);
        check_value(16'(pi_ad_oe), 16'd0, "bus drive after read_n high");
        shadow_addr = shadow_addr + 32'd2;
    endtask

    task automatic read_check(input string what);
        logic [15:0] expected;
        logic [15:0] got;
        expected = model_read(shadow_addr);
        pi_read(got);
        check_value(got, expected, what);
    endtask

    initial begin
        #(TOTAL_OPS * 40 * CLK_PERIOD);
        $display("ERROR at %0t ns: watchdog expired before the tests finished", $time);
        abort_run();
    end

    initial begin
        logic [31:0] addr;
        logic [3:0]  region;
        logic [7:0]  word;
        int          i;
        rst_n       = 1'b0;
        pi_aleh     = 1'b0;
        pi_alel     = 1'b0;
        pi_read_n   = 1'b1;
        pi_write_n  = 1'b1;
        pi_ad_in    = '0;
        model_irq   = 1'b0;
        shadow_addr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value(16'(pi_ad_oe), 16'd0, "bus drive after reset");
        check_value(16'(n64_irq), 16'd0, "irq after reset");

        // Random writes, each read back at some later point.
        for (i = 0; i < N_RANDOM; i++) begin
            word = 8'(rand_bits(8));
            addr = {cart_pkg::REGION_ROM, 19'(rand_bits(19)), word, 1'b0};
            pi_set_addr(addr);
            pi_write(16'(rand_bits(16)));
            pending.push_back(addr);
            written.push_back(word);
            if (rand_bits(1) != 0) begin
                pi_set_addr(pending.pop_front());
                read_check("random read-back");
            end
        end
        while (pending.size() > 0) begin
            pi_set_addr(pending.pop_front());
            read_check("random read-back");
        end

        // Burst with auto-increment.
        addr = {cart_pkg::REGION_ROM, 19'd0, 8'(rand_bits(8)), 1'b0};
        pi_set_addr(addr);
        for (i = 0; i < N_BURST; i++) begin
            pi_write(16'(rand_bits(16)));
        end
        pi_set_addr(addr);
        for (i = 0; i < N_BURST; i++) begin
            read_check("burst read");
        end

        // Interrupt set, then clear.
        for (i = 1; i >= 0; i--) begin
            pi_set_addr({cart_pkg::REGION_CFG, 28'd0});
            pi_write({15'(rand_bits(15)), i[0]});
            check_value(16'(n64_irq), 16'(model_irq), "irq pin after status write");
            pi_set_addr({cart_pkg::REGION_CFG, 28'd0});
            read_check("status read");
        end

        for (i = 0; i < N_UNMAPPED; i++) begin
            region = 4'(rand_bits(4));
            while (region == cart_pkg::REGION_ROM || region == cart_pkg::REGION_CFG) begin
                region = 4'(rand_bits(4));
            end
            word = written[rand_bits(8) % written.size()];
            addr = {region, 19'(rand_bits(19)), word, 1'b0};
            pi_set_addr(addr);
            read_check("unmapped read");
            pi_set_addr(addr);
            pi_write(16'(rand_bits(16)));
            pi_set_addr({cart_pkg::REGION_ROM, 19'd0, word, 1'b0});
            read_check("ROM word after unmapped write");
        end

        // Last of three writes to one word must win.
        for (i = 0; i < N_ORDER; i++) begin
            addr = {cart_pkg::REGION_ROM, 19'd0, 8'(rand_bits(8)), 1'b0};
            repeat (3) begin
                pi_set_addr(addr);
                pi_write(16'(rand_bits(16)));
            end
            pi_set_addr(addr);
            read_check("read after three writes");
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- tb/cart_pi_assertions.sv
`timescale 1ns/10ps

module cart_pi_assertions (
    input logic                          i_clk,
    input logic                          i_rst_n,
    input logic                          i_push,
    input logic                          i_pop,
    input logic                          i_full,
    input logic                          i_empty,
    input logic [cart_pkg::FIFO_PTR_W:0] i_count
);

    // The frontend holds a request back while the queue is full.
    no_push_when_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_push && i_full)
    ) else $error("FIFO push while full");

    no_pop_when_empty: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) !(i_pop && i_empty)
    ) else $error("FIFO pop while empty");

    count_in_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_count <= cart_pkg::FIFO_DEPTH
    ) else $error("FIFO count above depth");

endmodule

//--- rtl/cart_pi_top.sv
`timescale 1ns/10ps

module cart_pi_top (
    input  logic                          i_clk,
    input  logic                          i_rst_n,

    input  logic                          i_pi_aleh,
    input  logic                          i_pi_alel,
    input  logic                          i_pi_read_n,
    input  logic                          i_pi_write_n,
    input  logic [cart_pkg::PI_AD_W-1:0]  i_pi_ad,
    output logic [cart_pkg::PI_AD_W-1:0]  o_pi_ad,
    output logic                          o_pi_ad_oe,

    output logic                          o_n64_irq
);

    cart_pkg::pi_request_t        fe_req;
    cart_pkg::pi_request_t        head_req;
    logic                         req_push;
    logic                         req_pop;
    logic                         fifo_full;
    logic                         fifo_empty;
    logic [cart_pkg::PI_AD_W-1:0] rdata;
    logic                         rdata_valid;

    n64_pi_frontend n64_pi_frontend_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_pi_aleh(i_pi_aleh),
        .i_pi_alel(i_pi_alel),
        .i_pi_read_n(i_pi_read_n),
        .i_pi_write_n(i_pi_write_n),
        .i_pi_ad(i_pi_ad),
        .o_pi_ad(o_pi_ad),
        .o_pi_ad_oe(o_pi_ad_oe),
        .o_req(fe_req),
        .o_req_push(req_push),
        .i_req_full(fifo_full),
        .i_rdata(rdata),
        .i_rdata_valid(rdata_valid)
    );

    pi_request_fifo pi_request_fifo_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_push(req_push),
        .i_data(fe_req),
        .i_pop(req_pop),
        .o_data(head_req),
        .o_full(fifo_full),
        .o_empty(fifo_empty)
    );

    cart_memory_ctrl cart_memory_ctrl_inst (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_req(head_req),
        .i_empty(fifo_empty),
        .o_pop(req_pop),
        .o_rdata(rdata),
        .o_rdata_valid(rdata_valid),
        .o_irq(o_n64_irq)
    );

endmodule

//--- rtl/cart_memory_ctrl.sv
`timescale 1ns/10ps

module cart_memory_ctrl (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  cart_pkg::pi_request_t         i_req,
    input  logic                          i_empty,
    output logic                          o_pop,
    output logic [cart_pkg::PI_AD_W-1:0]  o_rdata,
    output logic                          o_rdata_valid,
    output logic                          o_irq
);

    logic [cart_pkg::PI_AD_W-1:0] ram [cart_pkg::MEM_WORDS];
    logic [cart_pkg::PI_AD_W-1:0] ram_q;
    logic                         is_rom;
    logic                         is_cfg;
    logic                         rd_valid_q;
    logic                         rd_rom_q;
    logic                         rd_cfg_q;
    logic                         irq_q;

    assign o_pop  = ~i_empty;  // One entry served per cycle.
    assign is_rom = (i_req.addr.fields.region == cart_pkg::REGION_ROM);
    assign is_cfg = (i_req.addr.fields.region == cart_pkg::REGION_CFG) &&
                    (i_req.addr.fields.word == '0);

    always_ff @(posedge i_clk) begin
        if (o_pop && is_rom && i_req.write) begin
            ram[i_req.addr.fields.word] <= i_req.wdata;
        end
        ram_q <= ram[i_req.addr.fields.word];
    end

    // Read bookkeeping lines up with the RAM output.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_valid_q <= 1'b0;
            rd_rom_q   <= 1'b0;
            rd_cfg_q   <= 1'b0;
        end else begin
            rd_valid_q <= o_pop & ~i_req.write;
            rd_rom_q   <= is_rom;
            rd_cfg_q   <= is_cfg;
        end
    end

    // Status register, bit 0 is the cartridge interrupt.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            irq_q <= 1'b0;
        end else if (o_pop && is_cfg && i_req.write) begin
            irq_q <= i_req.wdata[0];
        end
    end

    always_comb begin
        if (rd_rom_q) begin
            o_rdata = ram_q;
        end else if (rd_cfg_q) begin
            o_rdata = {{(cart_pkg::PI_AD_W-1){1'b0}}, irq_q};
        end else begin
            o_rdata = '0;  // Unmapped.
        end
    end

    assign o_rdata_valid = rd_valid_q;
    assign o_irq         = irq_q;

endmodule

//--- rtl/pi_request_fifo.sv
`timescale 1ns/10ps

module pi_request_fifo (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_push,
    input  cart_pkg::pi_request_t  i_data,
    input  logic                   i_pop,
    output cart_pkg::pi_request_t  o_data,
    output logic                   o_full,
    output logic                   o_empty
);

    cart_pkg::pi_request_t           entries [cart_pkg::FIFO_DEPTH];
    logic [cart_pkg::FIFO_PTR_W-1:0] wr_ptr;
    logic [cart_pkg::FIFO_PTR_W-1:0] rd_ptr;
    logic [cart_pkg::FIFO_PTR_W:0]   count;
    logic                            do_push;
    logic                            do_pop;

    assign o_full  = (count == cart_pkg::FIFO_DEPTH);
    assign o_empty = (count == '0);
    assign do_push = i_push & ~o_full;   // Push on full is dropped.
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            entries[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap naturally at the power-of-two depth.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + do_push - do_pop;
        end
    end

    assign o_data = entries[rd_ptr];  // Head is visible without a pop.

endmodule

//--- rtl/n64_pi_frontend.sv
`timescale 1ns/10ps

module n64_pi_frontend (
    input  logic                          i_clk,
    input  logic                          i_rst_n,

    input  logic                          i_pi_aleh,
    input  logic                          i_pi_alel,
    input  logic                          i_pi_read_n,
    input  logic                          i_pi_write_n,
    input  logic [cart_pkg::PI_AD_W-1:0]  i_pi_ad,
    output logic [cart_pkg::PI_AD_W-1:0]  o_pi_ad,
    output logic                          o_pi_ad_oe,

    output cart_pkg::pi_request_t         o_req,
    output logic                          o_req_push,
    input  logic                          i_req_full,

    input  logic [cart_pkg::PI_AD_W-1:0]  i_rdata,
    input  logic                          i_rdata_valid
);

    logic                         read_n_q;
    logic                         write_n_q;
    logic                         read_fall;
    logic                         read_rise;
    logic                         write_rise;
    cart_pkg::pi_addr_u           addr_q;
    cart_pkg::pi_request_t        pend_q;
    logic                         pend_valid_q;
    logic [cart_pkg::PI_AD_W-1:0] rdata_q;
    logic                         oe_q;

    assign read_fall  = read_n_q & ~i_pi_read_n;
    assign read_rise  = ~read_n_q & i_pi_read_n;
    assign write_rise = ~write_n_q & i_pi_write_n;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            read_n_q  <= 1'b1;  // Strobes idle high.
            write_n_q <= 1'b1;
        end else begin
            read_n_q  <= i_pi_read_n;
            write_n_q <= i_pi_write_n;
        end
    end

    // Address latch, high half first, then low half, then +2 per strobe.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            addr_q.raw <= '0;
        end else if (i_pi_aleh) begin
            addr_q.raw[31:16] <= i_pi_ad;
        end else if (i_pi_alel) begin
            addr_q.raw[15:0] <= i_pi_ad;
        end else if (read_rise || write_rise) begin
            addr_q.raw <= addr_q.raw + 32'd2;
        end
    end

    // One-entry hold for a request that finds the FIFO full.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend_valid_q <= 1'b0;
        end else if (write_rise || read_fall) begin
            pend_valid_q <= 1'b1;
        end else if (o_req_push) begin
            pend_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (write_rise) begin
            pend_q.write <= 1'b1;
            pend_q.addr  <= addr_q;   // Address before the increment.
            pend_q.wdata <= i_pi_ad;
        end else if (read_fall) begin
            pend_q.write <= 1'b0;
            pend_q.addr  <= addr_q;
            pend_q.wdata <= '0;
        end
    end

    assign o_req      = pend_q;
    assign o_req_push = pend_valid_q & ~i_req_full;

    always_ff @(posedge i_clk) begin
        if (i_rdata_valid) begin
            rdata_q <= i_rdata;
        end
    end

    // Drive until the host releases read_n.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            oe_q <= 1'b0;
        end else if (i_rdata_valid) begin
            oe_q <= 1'b1;
        end else if (i_pi_read_n) begin
            oe_q <= 1'b0;
        end
    end

    assign o_pi_ad    = rdata_q;
    assign o_pi_ad_oe = oe_q;

endmodule

//--- rtl/cart_pkg.sv
package cart_pkg;

    // Bus and memory sizes.
    localparam int PI_AD_W    = 16;
    localparam int MEM_WORDS  = 256;  // ROM window, 16-bit words.
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // Region codes found in address bits 31:28.
    localparam logic [3:0] REGION_ROM = 4'h1;
    localparam logic [3:0] REGION_CFG = 4'h8;

    // Decode view of a PI address.
    typedef struct packed {
        logic [3:0]  region;    // Bits 31:28.
        logic [18:0] unused;    // Bits 27:9.
        logic [7:0]  word;      // Bits 8:1, 16-bit word index.
        logic        byte_sel;  // Bit 0.
    } pi_addr_fields_t;

    // The same 32-bit address, either raw or split into fields.
    typedef union packed {
        logic [31:0]     raw;
        pi_addr_fields_t fields;
    } pi_addr_u;

    // One queued PI access.
    typedef struct packed {
        logic                 write;
        pi_addr_u             addr;
        logic [PI_AD_W-1:0]   wdata;  // Ignored for reads.
    } pi_request_t;

endpackage
